//--- logic/uart_pkg.sv
package uart_pkg;

  // Word offsets of the register map, offset 7 is reserved
  typedef enum logic [2:0] {
    addr_txdata = 3'd0,
    addr_rxdata = 3'd1,
    addr_txctrl = 3'd2,
    addr_rxctrl = 3'd3,
    addr_ie     = 3'd4,
    addr_ip     = 3'd5,
    addr_div    = 3'd6
  } reg_addr_e;

  // Wishbone access sequencing
  typedef enum logic [1:0] {
    bus_idle,
    bus_access,
    bus_respond
  } bus_state_e;

  localparam int fifo_depth = 8;
  localparam int ptr_width = $clog2(fifo_depth);

  // Fill level spans 0 to fifo_depth
  localparam int level_width = 4;
  localparam int watermark_width = 3;

  localparam int clock_freq_hz = 250_000_000;

  // 115200 baud at the system clock
  localparam logic [15:0] div_init = 16'(clock_freq_hz / 115200 - 1);

endpackage

//--- logic/uart_bus_fsm.sv
`timescale 1ns/1ns

module uart_bus_fsm (
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] rd_data,
  output logic        bank_wr_en,
  output logic        bank_rd_en,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r
);

  uart_pkg::bus_state_e state;
  uart_pkg::bus_state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      uart_pkg::bus_idle: begin
        if (wb_cyc && wb_stb) begin
          state_next = uart_pkg::bus_access;
        end
      end
      uart_pkg::bus_access: begin
        state_next = uart_pkg::bus_respond;
      end
      default: begin
        state_next = uart_pkg::bus_idle;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= uart_pkg::bus_idle;
    end else begin
      state <= state_next;
    end
  end

  // Exactly one bank strobe per request
  assign bank_wr_en = (state == uart_pkg::bus_access) && wb_we;
  assign bank_rd_en = (state == uart_pkg::bus_access) && !wb_we;

  assign wb_ack = (state == uart_pkg::bus_respond);

  // Bank read word settles in respond, after any pop in access
  assign wb_dat_r = (state == uart_pkg::bus_respond) ? rd_data : '0;

  // Ack answers a request still held during access, for one cycle only
  ack_single_cycle: assert property (
    @(posedge clock) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb) ##1 !wb_ack
  );

endmodule

//--- logic/uart_fifo.sv
`timescale 1ns/1ns

module uart_fifo (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             push,
  input  logic                             pop,
  input  logic [7:0]                       wr_data,
  output logic [7:0]                       rd_data,
  output logic [uart_pkg::level_width-1:0] level
);

  logic [7:0]                     mem [uart_pkg::fifo_depth];
  logic [uart_pkg::ptr_width-1:0] wr_ptr;
  logic [uart_pkg::ptr_width-1:0] rd_ptr;
  logic                           full;
  logic                           empty;
  logic                           do_push;
  logic                           do_pop;

  assign full  = (level == uart_pkg::fifo_depth);
  assign empty = (level == '0);

  // Pop frees the head slot in the same cycle
  assign do_push = push && (!full || pop);
  assign do_pop  = pop && !empty;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  assign rd_data = mem[rd_ptr];

  // Overflowing push is lost, pointers still meet at full
  overflow_dropped: assert property (
    @(posedge clock) disable iff (reset)
    (full && push && !pop) |=>
      (level == uart_pkg::fifo_depth) && $stable(wr_ptr) && (wr_ptr == rd_ptr)
  );

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic        clock,
  input  logic        reset,
  input  logic        txen,
  input  logic        nstop,
  input  logic        fifo_empty,
  input  logic [15:0] div,
  input  logic [7:0]  data,
  output logic        pop,
  output logic        txd
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_e;

  tx_state_e   state;
  logic [15:0] baud_cnt;
  logic [2:0]  bit_cnt;
  logic [7:0]  shift;
  logic        bit_done;

  // Each bit lasts div + 1 clocks
  assign bit_done = (baud_cnt == div);
  assign pop = (state == tx_idle) && txen && !fifo_empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= tx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
    end else begin
      if ((state == tx_idle) || bit_done) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      case (state)
        tx_idle: begin
          if (pop) begin
            txd   <= 1'b0;
            state <= tx_start;
          end
        end
        tx_start: begin
          if (bit_done) begin
            txd     <= shift[0];
            bit_cnt <= '0;
            state   <= tx_data;
          end
        end
        tx_data: begin
          if (bit_done) begin
            if (bit_cnt == 3'd7) begin
              txd     <= 1'b1;
              bit_cnt <= '0;
              state   <= tx_stop;
            end else begin
              txd     <= shift[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: begin
          if (bit_done) begin
            // Second stop bit when nstop is set
            if (nstop && (bit_cnt == 3'd0)) begin
              bit_cnt <= 3'd1;
            end else begin
              state <= tx_idle;
            end
          end
        end
      endcase
    end
  end

  // LSB first
  always_ff @(posedge clock) begin
    if (pop) begin
      shift <= data;
    end else if (bit_done && ((state == tx_start) || (state == tx_data))) begin
      shift <= shift >> 1;
    end
  end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic        clock,
  input  logic        reset,
  input  logic        rxen,
  input  logic        rxd,
  input  logic [15:0] div,
  output logic        push,
  output logic [7:0]  data
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e   state;
  logic        rxd_meta;
  logic        rxd_sync;
  logic [15:0] baud_cnt;
  logic [2:0]  bit_cnt;
  logic        half_done;
  logic        bit_done;
  logic        restart;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // Half a bit to reach the middle of the start bit
  assign half_done = (baud_cnt == (div >> 1));
  assign bit_done  = (baud_cnt == div);
  assign restart   = (state == rx_idle) || ((state == rx_start) ? half_done : bit_done);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0;
      if (restart) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      case (state)
        rx_idle: begin
          if (rxen && !rxd_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (half_done) begin
            // Glitch shorter than half a bit
            state   <= rxd_sync ? rx_idle : rx_data;
            bit_cnt <= '0;
          end
        end
        rx_data: begin
          if (bit_done) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        default: begin
          if (bit_done) begin
            push  <= rxd_sync;
            state <= rx_idle;
          end
        end
      endcase
      if (!rxen) begin
        state <= rx_idle;
      end
    end
  end

  always_ff @(posedge clock) begin
    if ((state == rx_data) && bit_done) begin
      data <= {rxd_sync, data[7:1]};
    end
  end

endmodule

//--- logic/uart_bank.sv
`timescale 1ns/1ns

module uart_bank (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             bank_wr_en,
  input  logic                             bank_rd_en,
  input  logic [2:0]                       addr,
  input  logic [31:0]                      wr_data,
  output logic [31:0]                      rd_data,
  output logic                             tx_push,
  output logic                             rx_pop,
  output logic [7:0]                       tx_fifo_wr_data,
  input  logic [7:0]                       rx_fifo_rd_data,
  input  logic [uart_pkg::level_width-1:0] tx_level,
  input  logic [uart_pkg::level_width-1:0] rx_level,
  output logic                             txen,
  output logic                             rxen,
  output logic                             nstop,
  output logic [15:0]                      div,
  output logic                             interrupt
);

  logic [uart_pkg::watermark_width-1:0] txcnt;
  logic [uart_pkg::watermark_width-1:0] rxcnt;
  logic                                 tx_ie;
  logic                                 rx_ie;
  logic [7:0]                           rx_data_q;
  logic                                 rx_empty_q;
  logic                                 tx_full;
  logic                                 rx_empty;
  logic                                 tx_pending;
  logic                                 rx_pending;
  logic                                 wr_txdata;
  logic                                 wr_txctrl;
  logic                                 wr_rxctrl;
  logic                                 wr_ie;
  logic                                 wr_div;
  logic                                 rd_rxdata;

  assign wr_txdata = bank_wr_en && (addr == uart_pkg::addr_txdata);
  assign wr_txctrl = bank_wr_en && (addr == uart_pkg::addr_txctrl);
  assign wr_rxctrl = bank_wr_en && (addr == uart_pkg::addr_rxctrl);
  assign wr_ie     = bank_wr_en && (addr == uart_pkg::addr_ie);
  assign wr_div    = bank_wr_en && (addr == uart_pkg::addr_div);
  assign rd_rxdata = bank_rd_en && (addr == uart_pkg::addr_rxdata);

  assign tx_full  = (tx_level == uart_pkg::fifo_depth);
  assign rx_empty = (rx_level == '0);

  // Writes to a full transmit FIFO are dropped
  assign tx_push         = wr_txdata && !tx_full;
  assign tx_fifo_wr_data = wr_data[7:0];
  assign rx_pop          = rd_rxdata && !rx_empty;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      txen  <= 1'b0;
      nstop <= 1'b0;
      txcnt <= '0;
      rxen  <= 1'b0;
      rxcnt <= '0;
      tx_ie <= 1'b0;
      rx_ie <= 1'b0;
      div   <= uart_pkg::div_init;
    end else begin
      if (wr_txctrl) begin
        txen  <= wr_data[0];
        nstop <= wr_data[1];
        txcnt <= wr_data[18:16];
      end
      if (wr_rxctrl) begin
        rxen  <= wr_data[0];
        rxcnt <= wr_data[18:16];
      end
      if (wr_ie) begin
        tx_ie <= wr_data[0];
        rx_ie <= wr_data[1];
      end
      if (wr_div) begin
        div <= wr_data[15:0];
      end
    end
  end

  // Byte and empty flag as seen just before the pop
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_data_q  <= '0;
      rx_empty_q <= 1'b1;
    end else begin
      if (rd_rxdata) begin
        rx_empty_q <= rx_empty;
      end
      if (rx_pop) begin
        rx_data_q <= rx_fifo_rd_data;
      end
    end
  end

  // Watermark conditions
  assign tx_pending = (tx_level < {1'b0, txcnt});
  assign rx_pending = (rx_level > {1'b0, rxcnt});
  assign interrupt  = (tx_pending && tx_ie) || (rx_pending && rx_ie);

  always_comb begin
    case (addr)
      uart_pkg::addr_txdata: rd_data = {tx_full, 31'b0};
      uart_pkg::addr_rxdata: rd_data = {rx_empty_q, 23'b0, rx_data_q};
      uart_pkg::addr_txctrl: rd_data = {13'b0, txcnt, 14'b0, nstop, txen};
      uart_pkg::addr_rxctrl: rd_data = {13'b0, rxcnt, 15'b0, rxen};
      uart_pkg::addr_ie:     rd_data = {30'b0, rx_ie, tx_ie};
      uart_pkg::addr_ip:     rd_data = {30'b0, rx_pending, tx_pending};
      uart_pkg::addr_div:    rd_data = {16'b0, div};
      default:               rd_data = '0;
    endcase
  end

  tx_push_below_depth: assert property (
    @(posedge clock) disable iff (reset) tx_push |-> (tx_level < uart_pkg::fifo_depth)
  );

  // Pop only from a FIFO whose level is in range
  rx_pop_not_empty: assert property (
    @(posedge clock) disable iff (reset)
    rx_pop |-> (rx_level != '0) && (rx_level <= uart_pkg::fifo_depth)
  );

endmodule

//--- logic/uart_top.sv
`timescale 1ns/1ns

module uart_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [2:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic        txd,
  input  logic        rxd,
  output logic        interrupt
);

  logic                             bank_wr_en;
  logic                             bank_rd_en;
  logic [31:0]                      rd_data;
  logic                             tx_push;
  logic                             rx_pop;
  logic [7:0]                       tx_fifo_wr_data;
  logic [7:0]                       rx_fifo_rd_data;
  logic [uart_pkg::level_width-1:0] tx_level;
  logic [uart_pkg::level_width-1:0] rx_level;
  logic                             txen;
  logic                             rxen;
  logic                             nstop;
  logic [15:0]                      div;
  logic                             tx_pop;
  logic [7:0]                       tx_fifo_rd_data;
  logic                             tx_fifo_empty;
  logic                             rx_push;
  logic [7:0]                       rx_byte;

  assign tx_fifo_empty = (tx_level == '0);

  uart_bus_fsm u_bus_fsm (
    .clock      (clock),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .rd_data    (rd_data),
    .bank_wr_en (bank_wr_en),
    .bank_rd_en (bank_rd_en),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r)
  );

  uart_bank u_bank (
    .clock           (clock),
    .reset           (reset),
    .bank_wr_en      (bank_wr_en),
    .bank_rd_en      (bank_rd_en),
    .addr            (wb_adr),
    .wr_data         (wb_dat_w),
    .rd_data         (rd_data),
    .tx_push         (tx_push),
    .rx_pop          (rx_pop),
    .tx_fifo_wr_data (tx_fifo_wr_data),
    .rx_fifo_rd_data (rx_fifo_rd_data),
    .tx_level        (tx_level),
    .rx_level        (rx_level),
    .txen            (txen),
    .rxen            (rxen),
    .nstop           (nstop),
    .div             (div),
    .interrupt       (interrupt)
  );

  uart_fifo u_tx_fifo (
    .clock   (clock),
    .reset   (reset),
    .push    (tx_push),
    .pop     (tx_pop),
    .wr_data (tx_fifo_wr_data),
    .rd_data (tx_fifo_rd_data),
    .level   (tx_level)
  );

  uart_fifo u_rx_fifo (
    .clock   (clock),
    .reset   (reset),
    .push    (rx_push),
    .pop     (rx_pop),
    .wr_data (rx_byte),
    .rd_data (rx_fifo_rd_data),
    .level   (rx_level)
  );

  uart_tx u_tx (
    .clock      (clock),
    .reset      (reset),
    .txen       (txen),
    .nstop      (nstop),
    .fifo_empty (tx_fifo_empty),
    .div        (div),
    .data       (tx_fifo_rd_data),
    .pop        (tx_pop),
    .txd        (txd)
  );

  uart_rx u_rx (
    .clock (clock),
    .reset (reset),
    .rxen  (rxen),
    .rxd   (rxd),
    .div   (div),
    .push  (rx_push),
    .data  (rx_byte)
  );

endmodule

//--- tb/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;

  logic        clock;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        txd;
  logic        interrupt;

  // Reference model state
  logic        m_txen;
  logic        m_nstop;
  logic [2:0]  m_txcnt;
  logic        m_rxen;
  logic [2:0]  m_rxcnt;
  logic        m_tx_ie;
  logic        m_rx_ie;
  logic [15:0] m_div;
  int          m_tx_level;
  int          m_rx_level;
  logic [7:0]  m_rx_byte;
  logic        m_rx_empty;
  logic [7:0]  sent_q[$];

  string       chk_name;
  logic [31:0] chk_got;
  logic [31:0] chk_exp;
  event        chk_req;
  event        chk_done;
  int          mismatch_count;
  int          timeout_count;
  int          cycle_count;
  integer      seed;

  // Serial loopback
  uart_top u_dut (
    .clock     (clock),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .txd       (txd),
    .rxd       (txd),
    .interrupt (interrupt)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  always begin
    @(chk_req);
    if (chk_got !== chk_exp) begin
      mismatch_count++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, chk_name, chk_got, chk_exp);
    end
    -> chk_done;
  end

  function automatic logic [31:0] expected_word(input logic [2:0] adr);
    logic [31:0] w;
    w = '0;
    case (adr)
      uart_pkg::addr_txdata: w[31] = (m_tx_level >= uart_pkg::fifo_depth);
      uart_pkg::addr_rxdata: begin
        w[31]  = m_rx_empty;
        w[7:0] = m_rx_byte;
      end
      uart_pkg::addr_txctrl: begin
        w[0]     = m_txen;
        w[1]     = m_nstop;
        w[18:16] = m_txcnt;
      end
      uart_pkg::addr_rxctrl: begin
        w[0]     = m_rxen;
        w[18:16] = m_rxcnt;
      end
      uart_pkg::addr_ie: begin
        w[0] = m_tx_ie;
        w[1] = m_rx_ie;
      end
      uart_pkg::addr_ip: begin
        w[0] = (m_tx_level < m_txcnt);
        w[1] = (m_rx_level > m_rxcnt);
      end
      uart_pkg::addr_div: w[15:0] = m_div;
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic logic expected_irq();
    return ((m_tx_level < m_txcnt) && m_tx_ie) || ((m_rx_level > m_rxcnt) && m_rx_ie);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_name = name;
    chk_got  = got;
    chk_exp  = exp;
    -> chk_req;
    @(chk_done);
  endtask

  // One Wishbone classic cycle, entered 1 ns after a rising edge
  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] data,
                            output logic [31:0] rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    waited   = 0;
    rdata    = '0;
    while (!wb_ack && waited < 20) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      timeout_count++;
      $display("Timeout at %0t ns: no acknowledge for offset %0d", $time, adr);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clock);
    #1;
    // Ack lasts a single cycle
    check("wb_ack", wb_ack, 1'b0);
  endtask

  task automatic reg_write(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
    case (adr)
      uart_pkg::addr_txdata: begin
        if (m_tx_level < uart_pkg::fifo_depth) begin
          m_tx_level++;
          sent_q.push_back(data[7:0]);
        end
      end
      uart_pkg::addr_txctrl: begin
        m_txen  = data[0];
        m_nstop = data[1];
        m_txcnt = data[18:16];
      end
      uart_pkg::addr_rxctrl: begin
        m_rxen  = data[0];
        m_rxcnt = data[18:16];
      end
      uart_pkg::addr_ie: begin
        m_tx_ie = data[0];
        m_rx_ie = data[1];
      end
      uart_pkg::addr_div: m_div = data[15:0];
      default: ;
    endcase
  endtask

  // Receive FIFO is expected empty here
  task automatic reg_read_check(input logic [2:0] adr);
    logic [31:0] rdata;
    bus_access(1'b0, adr, '0, rdata);
    if (adr == uart_pkg::addr_rxdata) begin
      m_rx_empty = 1'b1;
    end
    check($sformatf("wb_dat_r @ offset %0d", adr), rdata, expected_word(adr));
  endtask

  task automatic receive_byte();
    logic [31:0] rdata;
    int start;
    start = cycle_count;
    rdata = 32'h8000_0000;
    while (rdata[31] && (cycle_count - start) < 2000) begin
      bus_access(1'b0, uart_pkg::addr_rxdata, '0, rdata);
    end
    if (rdata[31]) begin
      timeout_count++;
      $display("Timeout at %0t ns: no byte arrived in rxdata within 2000 cycles", $time);
    end else begin
      m_rx_empty = 1'b0;
      m_rx_byte  = sent_q.pop_front();
      check("wb_dat_r @ rxdata", rdata, expected_word(uart_pkg::addr_rxdata));
    end
  endtask

  // Cycles between the first two start edges on txd
  task automatic measure_start_gap(output int gap);
    int waited;
    int first_start;
    gap    = 0;
    waited = 0;
    while (txd && waited < 200) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (txd) begin
      timeout_count++;
      $display("Timeout at %0t ns: first start bit never appeared on txd", $time);
    end
    first_start = cycle_count;
    // Skip to the middle of the first stop bit
    while (cycle_count < first_start + 9 * (m_div + 1) + (m_div + 1) / 2) begin
      @(posedge clock);
      #1;
    end
    waited = 0;
    while (txd && waited < 200) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (txd) begin
      timeout_count++;
      $display("Timeout at %0t ns: second start bit never appeared on txd", $time);
    end
    gap = cycle_count - first_start;
  endtask

  initial begin
    int waited;
    int gap;
    clock          = 1'b0;
    reset          = 1'b1;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    seed           = 7218;
    cycle_count    = 0;
    mismatch_count = 0;
    timeout_count  = 0;
    m_txen         = 1'b0;
    m_nstop        = 1'b0;
    m_txcnt        = '0;
    m_rxen         = 1'b0;
    m_rxcnt        = '0;
    m_tx_ie        = 1'b0;
    m_rx_ie        = 1'b0;
    m_div          = uart_pkg::div_init;
    m_tx_level     = 0;
    m_rx_level     = 0;
    m_rx_byte      = '0;
    m_rx_empty     = 1'b1;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    // Reset values
    for (int a = 0; a < 8; a++) begin
      reg_read_check(3'(a));
    end
    check("interrupt", interrupt, expected_irq());
    check("txd", txd, 1'b1);

    // Defined bits only, ip and offset 7 ignore writes
    reg_write(uart_pkg::addr_txctrl, 32'hffff_ffff);
    reg_write(uart_pkg::addr_rxctrl, 32'hffff_ffff);
    reg_write(uart_pkg::addr_ie, 32'hffff_ffff);
    reg_write(uart_pkg::addr_div, 32'hdead_0123);
    reg_write(uart_pkg::addr_ip, 32'hffff_ffff);
    reg_write(3'd7, 32'hffff_ffff);
    for (int a = 0; a < 8; a++) begin
      reg_read_check(3'(a));
    end
    check("interrupt", interrupt, expected_irq());
    reg_write(uart_pkg::addr_txctrl, 32'h0);
    reg_write(uart_pkg::addr_rxctrl, 32'h0);
    reg_write(uart_pkg::addr_ie, 32'h0);

    // Loopback of five bytes
    reg_write(uart_pkg::addr_div, 32'd7);
    reg_write(uart_pkg::addr_txctrl, 32'h1);
    reg_write(uart_pkg::addr_rxctrl, 32'h1);
    for (int i = 0; i < 5; i++) begin
      reg_write(uart_pkg::addr_txdata, $random(seed));
    end
    for (int i = 0; i < 5; i++) begin
      receive_byte();
    end
    m_tx_level = 0;
    reg_read_check(uart_pkg::addr_rxdata);
    reg_read_check(uart_pkg::addr_txdata);

    // Full transmit FIFO drops the ninth byte
    reg_write(uart_pkg::addr_txctrl, 32'h0);
    for (int i = 0; i < 9; i++) begin
      reg_write(uart_pkg::addr_txdata, $random(seed));
    end
    reg_read_check(uart_pkg::addr_txdata);
    reg_write(uart_pkg::addr_txctrl, 32'h1);
    for (int i = 0; i < 8; i++) begin
      receive_byte();
    end
    m_tx_level = 0;
    repeat (300) @(posedge clock);
    #1;
    reg_read_check(uart_pkg::addr_rxdata);
    reg_read_check(uart_pkg::addr_txdata);

    // Watermark interrupts
    reg_write(uart_pkg::addr_txctrl, 32'h0002_0000);
    reg_write(uart_pkg::addr_ie, 32'h1);
    check("interrupt", interrupt, expected_irq());
    reg_read_check(uart_pkg::addr_ip);
    for (int i = 0; i < 3; i++) begin
      reg_write(uart_pkg::addr_txdata, $random(seed));
    end
    check("interrupt", interrupt, expected_irq());
    reg_read_check(uart_pkg::addr_ip);
    reg_write(uart_pkg::addr_rxctrl, 32'h1);
    reg_write(uart_pkg::addr_ie, 32'h2);
    check("interrupt", interrupt, expected_irq());
    reg_write(uart_pkg::addr_txctrl, 32'h0002_0001);
    waited = 0;
    while (!interrupt && waited < 2000) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (!interrupt) begin
      timeout_count++;
      $display("Timeout at %0t ns: interrupt did not rise after a received byte", $time);
    end
    m_rx_level = 1;
    check("interrupt", interrupt, expected_irq());
    receive_byte();
    m_rx_level = 0;
    check("interrupt", interrupt, expected_irq());
    receive_byte();
    receive_byte();
    m_tx_level = 0;
    reg_write(uart_pkg::addr_ie, 32'h0);

    // Two stop bits
    reg_write(uart_pkg::addr_txctrl, 32'h2);
    reg_write(uart_pkg::addr_txdata, $random(seed));
    reg_write(uart_pkg::addr_txdata, $random(seed));
    fork
      measure_start_gap(gap);
      reg_write(uart_pkg::addr_txctrl, 32'h3);
    join
    check("txd start gap >= 11 bit times", gap >= 11 * (m_div + 1), 1'b1);
    receive_byte();
    receive_byte();
    m_tx_level = 0;

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
logic/uart_pkg.sv
logic/uart_bus_fsm.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_bank.sv
logic/uart_top.sv
tb/uart_tb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - logic/uart_pkg.sv
  - logic/uart_bus_fsm.sv
  - logic/uart_fifo.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/uart_bank.sv
  - logic/uart_top.sv
  - target: test
    files:
      - tb/uart_tb.sv
